//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_rr_wrapper
DUT_TOP   ?= rr_wrapper
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_rr_wrapper.sv
`timescale 1ns/10ps
`include "rr_consts.svh"

module tb_rr_wrapper import rr_pkg::*; ();

  localparam int SEED        = 32'h4ef7;
  // Idle cycles after a mode write cover ack and the staging pipe
  localparam int MODE_SETTLE = 6;
  // Slot, merge and count each add one cycle to the log path
  localparam int LOG_SETTLE  = 4;
  localparam int NUM_REC     = 6;
  // Well above the few hundred cycles the whole run takes
  localparam int MAX_CYCLES  = 4000;

  logic                  clk;
  logic                  i_rst_n;
  logic                  i_ocl_valid;
  logic [`RR_ADDR_W-1:0] i_ocl_addr;
  logic [`RR_DATA_W-1:0] i_ocl_data;
  logic                  o_ocl_ready;
  logic                  i_sda_valid;
  logic [`RR_ADDR_W-1:0] i_sda_addr;
  logic [`RR_DATA_W-1:0] i_sda_data;
  logic                  o_sda_ready;
  logic                  o_core_ocl_valid;
  logic [`RR_ADDR_W-1:0] o_core_ocl_addr;
  logic [`RR_DATA_W-1:0] o_core_ocl_data;
  logic                  i_core_ocl_ready;
  logic                  o_core_sda_valid;
  logic [`RR_ADDR_W-1:0] o_core_sda_addr;
  logic [`RR_DATA_W-1:0] o_core_sda_data;
  logic                  i_core_sda_ready;
  logic                  i_cfg_req;
  logic [`RR_ADDR_W-1:0] i_cfg_addr;
  logic [`RR_DATA_W-1:0] i_cfg_data;
  logic                  o_cfg_ack;
  rr_mode_e              o_mode;
  logic [`RR_CNT_W-1:0]  o_trace_count;

  int errors;
  int checks;
  int cycle_cnt;
  // Recorded writes per channel in issue order
  rr_log_entry_t exp_ocl [$];
  rr_log_entry_t exp_sda [$];

  rr_wrapper u_dut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_entry(string what, rr_log_entry_t exp, rr_log_entry_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected chan/addr/data %0d/%h/%h, got %0d/%h/%h",
               $time, what, exp.chan, exp.addr, exp.data, got.chan, got.addr, got.data);
    end
  endtask

  task automatic check_mode(string what, rr_mode_e exp, rr_mode_e got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected mode %0d, got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_count(string what, logic [`RR_CNT_W-1:0] exp,
                             logic [`RR_CNT_W-1:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected count %0d, got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_flag(string what, logic exp, logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected %b, got %b", $time, what, exp, got);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Drivers and collector
  ////////////////////////////////////////////////////////////
  // Four-phase write, then wait for the new mode to settle
  task automatic cfg_write(logic [`RR_ADDR_W-1:0] addr, logic [`RR_DATA_W-1:0] data);
    @(negedge clk);
    i_cfg_req  = 1'b1;
    i_cfg_addr = addr;
    i_cfg_data = data;
    @(posedge clk);
    while (!o_cfg_ack) @(posedge clk);
    @(negedge clk);
    i_cfg_req = 1'b0;
    @(posedge clk);
    while (o_cfg_ack) @(posedge clk);
    repeat (MODE_SETTLE) @(posedge clk);
  endtask

  task automatic set_mode(rr_mode_e mode);
    cfg_write(`RR_ADDR_W'(`RR_CFG_MODE_ADDR), `RR_DATA_W'(mode));
  endtask

  // Called on a falling edge only
  task automatic drive_shell(logic valid, rr_log_entry_t e);
    if (e.chan == RR_CHAN_OCL) begin
      i_ocl_valid = valid;
      i_ocl_addr  = e.addr;
      i_ocl_data  = e.data;
    end else begin
      i_sda_valid = valid;
      i_sda_addr  = e.addr;
      i_sda_data  = e.data;
    end
  endtask

  function automatic logic shell_ready(rr_chan_e ch);
    return (ch == RR_CHAN_OCL) ? o_ocl_ready : o_sda_ready;
  endfunction

  // Hold valid until the edge that samples ready high
  task automatic release_on_accept(rr_log_entry_t e);
    @(posedge clk);
    while (!shell_ready(e.chan)) @(posedge clk);
    @(negedge clk);
    drive_shell(1'b0, e);
  endtask

  task automatic shell_write(rr_log_entry_t e);
    @(negedge clk);
    drive_shell(1'b1, e);
    release_on_accept(e);
  endtask

  // Returns the next completed write on one core channel
  task automatic collect_core(rr_chan_e ch, output rr_log_entry_t got);
    @(posedge clk);
    if (ch == RR_CHAN_OCL) begin
      while (!(o_core_ocl_valid && i_core_ocl_ready)) @(posedge clk);
      got = '{chan: ch, addr: o_core_ocl_addr, data: o_core_ocl_data};
    end else begin
      while (!(o_core_sda_valid && i_core_sda_ready)) @(posedge clk);
      got = '{chan: ch, addr: o_core_sda_addr, data: o_core_sda_data};
    end
  endtask

  // Random write on one channel
  // Core must see it unchanged
  task automatic write_and_collect(rr_chan_e ch, output rr_log_entry_t sent);
    rr_log_entry_t got;
    sent.chan = ch;
    sent.addr = `RR_ADDR_W'($urandom);
    sent.data = $urandom;
    fork
      shell_write(sent);
      collect_core(ch, got);
    join
    check_entry("core write", sent, got);
  endtask

  // Shell ready must stay low while valid is held
  task automatic expect_stall(rr_chan_e ch, int cycles);
    repeat (cycles) begin
      @(posedge clk);
      check_flag("stalled shell ready", 1'b0, shell_ready(ch));
    end
  endtask

  task automatic record_batch();
    rr_log_entry_t sent;
    exp_ocl.delete();
    exp_sda.delete();
    // Channel pattern 0 1 1 0 0 1 interleaves both ways
    for (int i = 0; i < NUM_REC; i++) begin
      write_and_collect(rr_chan_e'(i[0] ^ i[1]), sent);
      if (sent.chan == RR_CHAN_OCL) exp_ocl.push_back(sent);
      else exp_sda.push_back(sent);
    end
    repeat (LOG_SETTLE) @(posedge clk);
    check_count("recorded count", `RR_CNT_W'(NUM_REC), o_trace_count);
  endtask

  task automatic replay_collect(rr_chan_e ch);
    rr_log_entry_t got;
    rr_log_entry_t want;
    int            n;
    n = (ch == RR_CHAN_OCL) ? exp_ocl.size() : exp_sda.size();
    for (int i = 0; i < n; i++) begin
      collect_core(ch, got);
      want = (ch == RR_CHAN_OCL) ? exp_ocl[i] : exp_sda[i];
      check_entry("replayed write", want, got);
    end
  endtask

  task automatic report_test(string name, int errors_before);
    $display("%s done, %0d errors", name, errors - errors_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  task automatic pass_mode_test();
    rr_log_entry_t sent;
    check_mode("mode after reset", RR_MODE_PASS, o_mode);
    check_count("count after reset", `RR_CNT_W'(0), o_trace_count);
    check_flag("core ocl valid after reset", 1'b0, o_core_ocl_valid);
    check_flag("core sda valid after reset", 1'b0, o_core_sda_valid);
    check_flag("cfg ack after reset", 1'b0, o_cfg_ack);
    for (int i = 0; i < 4; i++) write_and_collect(rr_chan_e'(i[0]), sent);
    repeat (LOG_SETTLE) @(posedge clk);
    check_count("count in pass mode", `RR_CNT_W'(0), o_trace_count);
  endtask

  task automatic csr_test();
    set_mode(RR_MODE_RECORD);
    check_mode("mode after record write", RR_MODE_RECORD, o_mode);
    // Encoding 3 is not a mode
    cfg_write(`RR_ADDR_W'(`RR_CFG_MODE_ADDR), `RR_DATA_W'(3));
    check_mode("mode after illegal write", RR_MODE_RECORD, o_mode);
    set_mode(RR_MODE_PASS);
    check_mode("mode after pass write", RR_MODE_PASS, o_mode);
  endtask

  task automatic record_test();
    set_mode(RR_MODE_RECORD);
    record_batch();
    // Leaving and re-entering record mode wipes the trace
    set_mode(RR_MODE_PASS);
    check_count("count kept in pass mode", `RR_CNT_W'(NUM_REC), o_trace_count);
    set_mode(RR_MODE_RECORD);
    check_count("count after record re-entry", `RR_CNT_W'(0), o_trace_count);
    record_batch();
  endtask

  task automatic replay_test();
    // Replay starts during the mode settle, so collectors run alongside
    fork
      set_mode(RR_MODE_REPLAY);
      replay_collect(RR_CHAN_OCL);
      replay_collect(RR_CHAN_SDA);
    join
    check_mode("mode in replay", RR_MODE_REPLAY, o_mode);
    check_flag("ocl shell ready in replay", 1'b0, o_ocl_ready);
    check_flag("sda shell ready in replay", 1'b0, o_sda_ready);
    repeat (2) @(posedge clk);
    check_count("count after replay", `RR_CNT_W'(0), o_trace_count);
    check_flag("no extra ocl replay", 1'b0, o_core_ocl_valid);
    check_flag("no extra sda replay", 1'b0, o_core_sda_valid);
  endtask

  task automatic trace_full_test();
    rr_log_entry_t sent;
    set_mode(RR_MODE_RECORD);
    check_count("count after clear", `RR_CNT_W'(0), o_trace_count);
    // Past a full trace one entry parks in the merge register, one in the slot
    for (int i = 0; i < `RR_TRACE_DEPTH + 2; i++) write_and_collect(RR_CHAN_OCL, sent);
    @(negedge clk);
    drive_shell(1'b1, sent);
    expect_stall(RR_CHAN_OCL, 8);
    check_count("count at full", `RR_CNT_W'(`RR_TRACE_DEPTH), o_trace_count);
    // Unlogged write must not reach the core
    check_flag("core ocl valid at full", 1'b0, o_core_ocl_valid);
    @(negedge clk);
    drive_shell(1'b0, sent);
  endtask

  task automatic backpressure_test();
    rr_log_entry_t sent;
    rr_log_entry_t got;
    // Pass mode drains the parked entries and record entry clears the trace
    set_mode(RR_MODE_PASS);
    set_mode(RR_MODE_RECORD);
    sent = '{chan: RR_CHAN_OCL, addr: `RR_ADDR_W'($urandom), data: $urandom};
    @(negedge clk);
    i_core_ocl_ready = 1'b0;
    drive_shell(1'b1, sent);
    expect_stall(RR_CHAN_OCL, 6);
    check_count("count under back-pressure", `RR_CNT_W'(0), o_trace_count);
    @(negedge clk);
    i_core_ocl_ready = 1'b1;
    fork
      release_on_accept(sent);
      collect_core(RR_CHAN_OCL, got);
    join
    check_entry("core write after release", sent, got);
    repeat (LOG_SETTLE) @(posedge clk);
    check_count("count after release", `RR_CNT_W'(1), o_trace_count);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int e0;
    errors           = 0;
    checks           = 0;
    cycle_cnt        = 0;
    i_rst_n          = 1'b0;
    i_ocl_valid      = 1'b0;
    i_ocl_addr       = '0;
    i_ocl_data       = '0;
    i_sda_valid      = 1'b0;
    i_sda_addr       = '0;
    i_sda_data       = '0;
    i_core_ocl_ready = 1'b1;
    i_core_sda_ready = 1'b1;
    i_cfg_req        = 1'b0;
    i_cfg_addr       = '0;
    i_cfg_data       = '0;
    void'($urandom(SEED));
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    e0 = errors;
    pass_mode_test();
    report_test("pass mode", e0);
    e0 = errors;
    csr_test();
    report_test("mode csr", e0);
    e0 = errors;
    record_test();
    report_test("record", e0);
    e0 = errors;
    replay_test();
    report_test("replay", e0);
    e0 = errors;
    trace_full_test();
    report_test("trace full", e0);
    e0 = errors;
    backpressure_test();
    report_test("back-pressure", e0);

    $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_cnt);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+src
src/rr_pkg.sv
src/rr_wr_if.sv
src/rr_csrs.sv
src/rr_channel_recorder.sv
src/rr_log_merge.sv
src/rr_trace_buffer.sv
src/rr_channel_replayer.sv
src/rr_wrapper.sv
bench/tb_rr_wrapper.sv

//--- src/rr_channel_recorder.sv
`timescale 1ns/10ps
`include "rr_consts.svh"

module rr_channel_recorder import rr_pkg::*; (
  input  logic          clk,
  input  logic          i_rst_n,
  input  rr_mode_e      i_mode,
  input  rr_chan_e      i_chan,
  rr_wr_if.dst          shell,
  rr_wr_if.dst          replay,
  rr_wr_if.src          core,
  output logic          o_log_valid,
  output rr_log_entry_t o_log_entry,
  input  logic          i_log_ready
);

  logic replaying;
  logic recording;
  logic shell_open;
  logic log_xfer;

  assign replaying = (i_mode == RR_MODE_REPLAY);
  assign recording = (i_mode == RR_MODE_RECORD);

  // Shell may only proceed in record mode when the log slot has room
  // Slot frees in the same cycle the merge takes it
  assign shell_open = !recording || !o_log_valid || i_log_ready;

  // Source select, replay owns the core while replaying
  assign core.valid = replaying ? replay.valid : (shell.valid && shell_open);
  assign core.addr  = replaying ? replay.addr  : shell.addr;
  assign core.data  = replaying ? replay.data  : shell.data;

  // Shell is held off during replay
  assign shell.ready  = !replaying && shell_open && core.ready;
  assign replay.ready = replaying && core.ready;

  // Completed shell write while recording
  assign log_xfer = recording && shell.valid && shell.ready;

  // One-entry log slot
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_log_valid <= 1'b0;
    end else if (log_xfer) begin
      o_log_valid <= 1'b1;
    end else if (i_log_ready) begin
      o_log_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (log_xfer) begin
      o_log_entry <= '{chan: i_chan, addr: shell.addr, data: shell.data};
    end
  end

endmodule

//--- src/rr_channel_replayer.sv
`timescale 1ns/10ps
`include "rr_consts.svh"

module rr_channel_replayer import rr_pkg::*; (
  input  logic          clk,
  input  logic          i_rst_n,
  input  logic          i_entry_valid,
  input  rr_log_entry_t i_entry,
  output logic          o_entry_ready,
  rr_wr_if.src          wr
);

  logic                  full_q;
  logic [`RR_ADDR_W-1:0] addr_q;
  logic [`RR_DATA_W-1:0] data_q;

  // Takes a new entry when empty or when the held write completes now
  // Tag already picked this channel in the trace buffer
  assign o_entry_ready = !full_q || wr.ready;

  assign wr.valid = full_q;
  assign wr.addr  = addr_q;
  assign wr.data  = data_q;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      full_q <= 1'b0;
    end else if (o_entry_ready) begin
      full_q <= i_entry_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_entry_valid && o_entry_ready) begin
      addr_q <= i_entry.addr;
      data_q <= i_entry.data;
    end
  end

endmodule

//--- src/rr_consts.svh
`ifndef RR_CONSTS_SVH
`define RR_CONSTS_SVH

// Write channel geometry
`define RR_ADDR_W 16
`define RR_DATA_W 32

// Trace storage
`define RR_TRACE_DEPTH 16
// Count must hold the value RR_TRACE_DEPTH itself
`define RR_CNT_W 5

// Flops between the mode register and its users
`define RR_MODE_STAGES 2

// Configuration map
`define RR_CFG_MODE_ADDR 0

`endif

//--- src/rr_csrs.sv
`timescale 1ns/10ps
`include "rr_consts.svh"

module rr_csrs import rr_pkg::*; (
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_cfg_req,
  input  logic [`RR_ADDR_W-1:0] i_cfg_addr,
  input  logic [`RR_DATA_W-1:0] i_cfg_data,
  output logic                  o_cfg_ack,
  output rr_mode_e              o_mode
);

  typedef enum logic {
    CFG_IDLE,
    CFG_ACK
  } cfg_state_e;

  cfg_state_e state_q;
  rr_mode_e   mode_q;
  logic       cfg_wr;
  logic       mode_hit;
  // One flop beyond the stage count feeds the fanout to all channels
  rr_mode_e   mode_pipe_q [`RR_MODE_STAGES+1];

  ////////////////////////////////////////////////////////////
  // Four-phase config handshake
  ////////////////////////////////////////////////////////////
  // Write happens on the edge that takes req in idle
  assign cfg_wr    = (state_q == CFG_IDLE) && i_cfg_req;
  assign mode_hit  = cfg_wr && (i_cfg_addr == `RR_ADDR_W'(`RR_CFG_MODE_ADDR));
  assign o_cfg_ack = (state_q == CFG_ACK);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= CFG_IDLE;
    end else begin
      case (state_q)
        CFG_IDLE: if (i_cfg_req) state_q <= CFG_ACK;
        // Ack drops once the host lets go of req
        CFG_ACK:  if (!i_cfg_req) state_q <= CFG_IDLE;
        default:  state_q <= CFG_IDLE;
      endcase
    end
  end

  // Mode register, encodings above replay are dropped
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mode_q <= RR_MODE_PASS;
    end else if (mode_hit && (i_cfg_data <= `RR_DATA_W'(RR_MODE_REPLAY))) begin
      mode_q <= rr_mode_e'(i_cfg_data[1:0]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Mode staging
  ////////////////////////////////////////////////////////////
  // Recorders and trace buffer all switch on the same edge
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i <= `RR_MODE_STAGES; i++) begin
        mode_pipe_q[i] <= RR_MODE_PASS;
      end
    end else begin
      mode_pipe_q[0] <= mode_q;
      for (int i = 1; i <= `RR_MODE_STAGES; i++) begin
        mode_pipe_q[i] <= mode_pipe_q[i-1];
      end
    end
  end

  assign o_mode = mode_pipe_q[`RR_MODE_STAGES];

endmodule

//--- src/rr_log_merge.sv
`timescale 1ns/10ps
`include "rr_consts.svh"

module rr_log_merge import rr_pkg::*; (
  input  logic          clk,
  input  logic          i_rst_n,
  // Stream a
  input  logic          i_a_valid,
  input  rr_log_entry_t i_a_entry,
  output logic          o_a_ready,
  // Stream b
  input  logic          i_b_valid,
  input  rr_log_entry_t i_b_entry,
  output logic          o_b_ready,
  // Merged stream
  output logic          o_log_valid,
  output rr_log_entry_t o_log_entry,
  input  logic          i_log_ready
);

  logic out_free;
  logic grant_a;
  logic grant_b;
  // High when stream b wins a tie
  logic prio_b_q;

  // Output register can load when empty or draining this cycle
  assign out_free = !o_log_valid || i_log_ready;

  // Round-robin pick
  // A held output stalls both inputs
  assign grant_a = out_free && i_a_valid && (!i_b_valid || !prio_b_q);
  assign grant_b = out_free && i_b_valid && (!i_a_valid || prio_b_q);

  assign o_a_ready = grant_a;
  assign o_b_ready = grant_b;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_log_valid <= 1'b0;
      prio_b_q    <= 1'b0;
    end else begin
      if (out_free) o_log_valid <= grant_a || grant_b;
      // Priority moves to the stream that just lost
      if (grant_a || grant_b) prio_b_q <= grant_a;
    end
  end

  // Merged entry loads from the granted stream
  always_ff @(posedge clk) begin
    if (grant_a) begin
      o_log_entry <= i_a_entry;
    end else if (grant_b) begin
      o_log_entry <= i_b_entry;
    end
  end

endmodule

//--- src/rr_pkg.sv
`include "rr_consts.svh"

package rr_pkg;

  // Wrapper operating mode
  // Record and replay can never be on at the same time
  typedef enum logic [1:0] {
    RR_MODE_PASS   = 2'd0,
    RR_MODE_RECORD = 2'd1,
    RR_MODE_REPLAY = 2'd2
  } rr_mode_e;

  // Channel tag carried with every trace entry
  typedef enum logic {
    RR_CHAN_OCL = 1'b0,
    RR_CHAN_SDA = 1'b1
  } rr_chan_e;

  // One logged write, 49 bits
  // Tag sits on top so the trace is easy to read in a waveform
  typedef struct packed {
    rr_chan_e               chan;
    logic [`RR_ADDR_W-1:0]  addr;
    logic [`RR_DATA_W-1:0]  data;
  } rr_log_entry_t;

endpackage

//--- src/rr_trace_buffer.sv
`timescale 1ns/10ps
`include "rr_consts.svh"

module rr_trace_buffer import rr_pkg::*; (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  rr_mode_e             i_mode,
  // Record side
  input  logic                 i_log_valid,
  input  rr_log_entry_t        i_log_entry,
  output logic                 o_log_ready,
  // Replay side, one valid per channel
  output logic                 o_ocl_valid,
  output logic                 o_sda_valid,
  output rr_log_entry_t        o_rep_entry,
  input  logic                 i_ocl_ready,
  input  logic                 i_sda_ready,
  output logic [`RR_CNT_W-1:0] o_trace_count
);

  localparam int PTR_W = $clog2(`RR_TRACE_DEPTH);

  rr_log_entry_t      mem [`RR_TRACE_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  rr_mode_e           mode_q;
  logic               recording;
  logic               replaying;
  logic               clear;
  logic               full;
  logic               empty;
  logic               push;
  logic               pop;

  assign recording = (i_mode == RR_MODE_RECORD);
  assign replaying = (i_mode == RR_MODE_REPLAY);
  // First cycle of record mode wipes the old trace
  assign clear     = recording && (mode_q != RR_MODE_RECORD);
  assign full      = (o_trace_count == `RR_CNT_W'(`RR_TRACE_DEPTH));
  assign empty     = (o_trace_count == '0);

  ////////////////////////////////////////////////////////////
  // Record side
  ////////////////////////////////////////////////////////////
  // Outside record mode stray log entries are drained and dropped
  assign o_log_ready = !recording || !full;
  // Anything arriving with the clear predates record mode
  assign push        = recording && !clear && i_log_valid && !full;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr_q] <= i_log_entry;
  end

  ////////////////////////////////////////////////////////////
  // Replay side
  ////////////////////////////////////////////////////////////
  // Head goes only to the channel named in its tag
  assign o_rep_entry = mem[rd_ptr_q];
  assign o_ocl_valid = replaying && !empty && (o_rep_entry.chan == RR_CHAN_OCL);
  assign o_sda_valid = replaying && !empty && (o_rep_entry.chan == RR_CHAN_SDA);
  assign pop         = (o_ocl_valid && i_ocl_ready) || (o_sda_valid && i_sda_ready);

  // Pointers and count, push and pop never share a mode
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      o_trace_count <= '0;
      mode_q        <= RR_MODE_PASS;
    end else begin
      mode_q <= i_mode;
      if (clear) begin
        wr_ptr_q      <= '0;
        rd_ptr_q      <= '0;
        o_trace_count <= '0;
      end else if (push) begin
        wr_ptr_q      <= wr_ptr_q + 1'b1;
        o_trace_count <= o_trace_count + 1'b1;
      end else if (pop) begin
        rd_ptr_q      <= rd_ptr_q + 1'b1;
        o_trace_count <= o_trace_count - 1'b1;
      end
    end
  end

endmodule

//--- src/rr_wr_if.sv
`timescale 1ns/10ps
`include "rr_consts.svh"

// Valid/ready write channel
// Addr and data hold while valid is high and ready not yet sampled
interface rr_wr_if;
  logic                  valid;
  logic                  ready;
  logic [`RR_ADDR_W-1:0] addr;
  logic [`RR_DATA_W-1:0] data;

  // Side issuing the write
  modport src (output valid, output addr, output data, input ready);

  // Side taking the write
  modport dst (input valid, input addr, input data, output ready);

  // Observer only
  modport mon (input valid, input ready, input addr, input data);

endinterface

//--- src/rr_wrapper.sv
`timescale 1ns/10ps
`include "rr_consts.svh"

module rr_wrapper import rr_pkg::*; (
  input  logic                  clk,
  input  logic                  i_rst_n,
  // Shell side ocl and sda writes
  input  logic                  i_ocl_valid,
  input  logic [`RR_ADDR_W-1:0] i_ocl_addr,
  input  logic [`RR_DATA_W-1:0] i_ocl_data,
  output logic                  o_ocl_ready,
  input  logic                  i_sda_valid,
  input  logic [`RR_ADDR_W-1:0] i_sda_addr,
  input  logic [`RR_DATA_W-1:0] i_sda_data,
  output logic                  o_sda_ready,
  // Core side ocl and sda writes
  output logic                  o_core_ocl_valid,
  output logic [`RR_ADDR_W-1:0] o_core_ocl_addr,
  output logic [`RR_DATA_W-1:0] o_core_ocl_data,
  input  logic                  i_core_ocl_ready,
  output logic                  o_core_sda_valid,
  output logic [`RR_ADDR_W-1:0] o_core_sda_addr,
  output logic [`RR_DATA_W-1:0] o_core_sda_data,
  input  logic                  i_core_sda_ready,
  // Configuration port
  input  logic                  i_cfg_req,
  input  logic [`RR_ADDR_W-1:0] i_cfg_addr,
  input  logic [`RR_DATA_W-1:0] i_cfg_data,
  output logic                  o_cfg_ack,
  output rr_mode_e              o_mode,
  output logic [`RR_CNT_W-1:0]  o_trace_count
);

  rr_wr_if ocl_shell_if ();
  rr_wr_if ocl_core_if ();
  rr_wr_if ocl_rep_if ();
  rr_wr_if sda_shell_if ();
  rr_wr_if sda_core_if ();
  rr_wr_if sda_rep_if ();

  logic          ocl_log_valid, ocl_log_ready;
  logic          sda_log_valid, sda_log_ready;
  logic          mrg_log_valid, mrg_log_ready;
  rr_log_entry_t ocl_log_entry, sda_log_entry, mrg_log_entry;
  logic          ocl_rep_valid, ocl_rep_ready;
  logic          sda_rep_valid, sda_rep_ready;
  rr_log_entry_t rep_entry;

  ////////////////////////////////////////////////////////////
  // Top ports onto the channel interfaces
  ////////////////////////////////////////////////////////////
  assign ocl_shell_if.valid = i_ocl_valid;
  assign ocl_shell_if.addr  = i_ocl_addr;
  assign ocl_shell_if.data  = i_ocl_data;
  assign o_ocl_ready        = ocl_shell_if.ready;
  assign sda_shell_if.valid = i_sda_valid;
  assign sda_shell_if.addr  = i_sda_addr;
  assign sda_shell_if.data  = i_sda_data;
  assign o_sda_ready        = sda_shell_if.ready;

  assign o_core_ocl_valid  = ocl_core_if.valid;
  assign o_core_ocl_addr   = ocl_core_if.addr;
  assign o_core_ocl_data   = ocl_core_if.data;
  assign ocl_core_if.ready = i_core_ocl_ready;
  assign o_core_sda_valid  = sda_core_if.valid;
  assign o_core_sda_addr   = sda_core_if.addr;
  assign o_core_sda_data   = sda_core_if.data;
  assign sda_core_if.ready = i_core_sda_ready;

  // Mode register and staging
  rr_csrs u_csrs (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_cfg_req(i_cfg_req), .i_cfg_addr(i_cfg_addr), .i_cfg_data(i_cfg_data),
    .o_cfg_ack(o_cfg_ack), .o_mode(o_mode)
  );

  ////////////////////////////////////////////////////////////
  // Record path
  ////////////////////////////////////////////////////////////
  rr_channel_recorder u_ocl_rec (
    .clk(clk), .i_rst_n(i_rst_n), .i_mode(o_mode), .i_chan(RR_CHAN_OCL),
    .shell(ocl_shell_if), .replay(ocl_rep_if), .core(ocl_core_if),
    .o_log_valid(ocl_log_valid), .o_log_entry(ocl_log_entry),
    .i_log_ready(ocl_log_ready)
  );

  rr_channel_recorder u_sda_rec (
    .clk(clk), .i_rst_n(i_rst_n), .i_mode(o_mode), .i_chan(RR_CHAN_SDA),
    .shell(sda_shell_if), .replay(sda_rep_if), .core(sda_core_if),
    .o_log_valid(sda_log_valid), .o_log_entry(sda_log_entry),
    .i_log_ready(sda_log_ready)
  );

  rr_log_merge u_merge (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_a_valid(ocl_log_valid), .i_a_entry(ocl_log_entry), .o_a_ready(ocl_log_ready),
    .i_b_valid(sda_log_valid), .i_b_entry(sda_log_entry), .o_b_ready(sda_log_ready),
    .o_log_valid(mrg_log_valid), .o_log_entry(mrg_log_entry),
    .i_log_ready(mrg_log_ready)
  );

  // Shared trace, one head keeps replay in recorded order
  rr_trace_buffer u_trace (
    .clk(clk), .i_rst_n(i_rst_n), .i_mode(o_mode),
    .i_log_valid(mrg_log_valid), .i_log_entry(mrg_log_entry),
    .o_log_ready(mrg_log_ready),
    .o_ocl_valid(ocl_rep_valid), .o_sda_valid(sda_rep_valid),
    .o_rep_entry(rep_entry),
    .i_ocl_ready(ocl_rep_ready), .i_sda_ready(sda_rep_ready),
    .o_trace_count(o_trace_count)
  );

  ////////////////////////////////////////////////////////////
  // Replay path
  ////////////////////////////////////////////////////////////
  rr_channel_replayer u_ocl_rep (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_entry_valid(ocl_rep_valid), .i_entry(rep_entry),
    .o_entry_ready(ocl_rep_ready), .wr(ocl_rep_if)
  );

  rr_channel_replayer u_sda_rep (
    .clk(clk), .i_rst_n(i_rst_n),
    .i_entry_valid(sda_rep_valid), .i_entry(rep_entry),
    .o_entry_ready(sda_rep_ready), .wr(sda_rep_if)
  );

endmodule
